// File: logic/agen_fifo.sv
// computed address queue
`timescale 1ns/1ps

module agen_fifo (
	input  logic clk,
	input  logic rst,
	input  logic a_valid,
	input  agen_pkg::agen_res_t a_res,
	output logic a_ready,
	output logic q_valid,
	output agen_pkg::agen_res_t q_res,
	input  logic q_ready
);

	agen_pkg::agen_res_t mem [agen_pkg::FIFO_DEPTH];

	logic [agen_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [agen_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [agen_pkg::FIFO_CNT_W-1:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count == agen_pkg::FIFO_FULL);

	// when full a write is still taken if the head leaves too
	assign a_ready = !full || q_ready;
	// head is visible the cycle after the write
	assign q_valid = (count != '0);
	assign q_res = mem[rd_ptr];

	assign do_wr = a_valid && a_ready;
	assign do_rd = q_valid && q_ready;

	// ==============================
	// storage
	// ==============================

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= a_res;
		end
	end

	// ==============================
	// pointers and occupancy
	// ==============================

	// depth is a power of two so the pointers wrap by themselves
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// count only moves when one side is idle
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/agen_pkg.sv
// address generation shared types
package agen_pkg;

	// ==============================
	// widths and sizes
	// ==============================

	localparam int ADDR_W = 32;
	// 64 byte cache lines
	localparam int LINE_BITS = 6;
	// signed displacement field
	localparam int DISP_W = 12;

	// address queue geometry
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);

	// ==============================
	// encodings
	// ==============================

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_LD  = 2'd1,
		OP_ST  = 2'd2,
		OP_AMO = 2'd3
	} opcode_e;

	// byte, wyde, tetra, octa
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} size_e;

	// ==============================
	// request records
	// ==============================

	// decoded memory operation from issue
	typedef struct packed {
		opcode_e opcode;
		size_e size;
		logic [ADDR_W-1:0] base;
		logic [ADDR_W-1:0] index;
		logic [1:0] scale;          // index shift amount
		logic [DISP_W-1:0] disp;
	} mem_op_t;

	// effective address as queued
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		opcode_e opcode;
		size_e size;
	} agen_res_t;

	// one cache line request beat
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic store;                // ST or AMO
		size_e size;
		logic first;
		logic last;
		logic err;                  // misaligned atomic
	} line_req_t;

endpackage

// File: logic/agen_top.sv
// load store address path
`timescale 1ns/1ps

module agen_top (
	input  logic clk,
	input  logic rst,
	input  logic op_valid,
	input  agen_pkg::mem_op_t op,
	output logic op_ready,
	output logic req_valid,
	output agen_pkg::line_req_t req,
	input  logic req_ready
);

	// ==============================
	// stage links
	// ==============================

	// generator to queue
	logic a_valid;
	agen_pkg::agen_res_t a_res;
	logic a_ready;

	// queue to splitter
	logic q_valid;
	agen_pkg::agen_res_t q_res;
	logic q_ready;

	// effective address, one cycle
	agen_unit u_agen (
		.clk      (clk),
		.rst      (rst),
		.op_valid (op_valid),
		.op       (op),
		.op_ready (op_ready),
		.a_valid  (a_valid),
		.a_res    (a_res),
		.a_ready  (a_ready)
	);

	// absorbs back-pressure from the memory side
	agen_fifo u_fifo (
		.clk     (clk),
		.rst     (rst),
		.a_valid (a_valid),
		.a_res   (a_res),
		.a_ready (a_ready),
		.q_valid (q_valid),
		.q_res   (q_res),
		.q_ready (q_ready)
	);

	// one or two line requests per address
	line_splitter u_split (
		.clk       (clk),
		.rst       (rst),
		.q_valid   (q_valid),
		.q_res     (q_res),
		.q_ready   (q_ready),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready)
	);

endmodule

// File: logic/agen_unit.sv
// effective address generator
`timescale 1ns/1ps

module agen_unit (
	input  logic clk,
	input  logic rst,
	input  logic op_valid,
	input  agen_pkg::mem_op_t op,
	output logic op_ready,
	output logic a_valid,
	output agen_pkg::agen_res_t a_res,
	input  logic a_ready
);

	logic [agen_pkg::ADDR_W-1:0] index_sh;
	logic [agen_pkg::ADDR_W-1:0] disp_ext;
	logic [agen_pkg::ADDR_W-1:0] ea;
	logic take_op;

	// ==============================
	// address arithmetic
	// ==============================

	// scaled index, scale is a plain left shift
	always_comb begin
		index_sh = op.index << op.scale;
	end

	// sign extend the 12 bit displacement
	always_comb begin
		disp_ext = {{(agen_pkg::ADDR_W - agen_pkg::DISP_W){op.disp[agen_pkg::DISP_W-1]}},
			op.disp};
	end

	always_comb begin
		case (op.opcode)
			// loads and stores use the full form
			agen_pkg::OP_LD,
			agen_pkg::OP_ST: ea = op.base + index_sh + disp_ext;
			// atomics take register plus register only
			agen_pkg::OP_AMO: ea = op.base + op.index;
			default: ea = op.base;
		endcase
	end

	// ==============================
	// output register
	// ==============================

	// room when empty or the held result leaves this cycle
	assign op_ready = !a_valid || a_ready;
	assign take_op = op_valid && op_ready;

	// sticky valid, set on a real op, cleared once taken
	// a nop is consumed here and never reaches the queue
	always_ff @(posedge clk) begin
		if (rst) begin
			a_valid <= 1'b0;
		end else if (op_ready) begin
			a_valid <= op_valid && (op.opcode != agen_pkg::OP_NOP);
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (take_op) begin
			a_res.addr <= ea;
			a_res.opcode <= op.opcode;
			a_res.size <= op.size;
		end
	end

endmodule

// File: logic/line_splitter.sv
// cache line request splitter
`timescale 1ns/1ps

module line_splitter (
	input  logic clk,
	input  logic rst,
	input  logic q_valid,
	input  agen_pkg::agen_res_t q_res,
	output logic q_ready,
	output logic req_valid,
	output agen_pkg::line_req_t req,
	input  logic req_ready
);

	// second beat pending for a split access
	typedef enum logic {
		ISSUE  = 1'b0,
		SECOND = 1'b1
	} state_e;

	state_e state;

	logic [3:0] size_bytes;
	logic [agen_pkg::LINE_BITS:0] line_end;
	logic crossing;
	logic is_amo;
	logic split;
	logic load_en;
	logic [agen_pkg::ADDR_W-1:0] next_line;
	agen_pkg::line_req_t next_req;

	// ==============================
	// line crossing detect
	// ==============================

	// 1, 2, 4 or 8 bytes
	assign size_bytes = 4'b0001 << q_res.size;

	// offset in line plus length, one bit wider than the offset
	assign line_end = {1'b0, q_res.addr[agen_pkg::LINE_BITS-1:0]}
		+ {{(agen_pkg::LINE_BITS - 3){1'b0}}, size_bytes};

	// past 64 means the top bit is set and something is left below it
	assign crossing = line_end[agen_pkg::LINE_BITS]
		&& (line_end[agen_pkg::LINE_BITS-1:0] != '0);

	assign is_amo = (q_res.opcode == agen_pkg::OP_AMO);
	// atomics are never split, they are flagged instead
	assign split = crossing && !is_amo;

	// start of the following line
	assign next_line = {q_res.addr[agen_pkg::ADDR_W-1:agen_pkg::LINE_BITS] + 1'b1,
		{agen_pkg::LINE_BITS{1'b0}}};

	// ==============================
	// beat selection
	// ==============================

	always_comb begin
		next_req.store = (q_res.opcode == agen_pkg::OP_ST) || is_amo;
		next_req.size = q_res.size;
		if (state == SECOND) begin
			next_req.addr = next_line;
			next_req.first = 1'b0;
			next_req.last = 1'b1;
			next_req.err = 1'b0;
		end else begin
			next_req.addr = q_res.addr;
			next_req.first = 1'b1;
			next_req.last = !split;
			next_req.err = crossing && is_amo;
		end
	end

	// output register free or draining this cycle
	assign load_en = !req_valid || req_ready;

	// entry leaves the queue with its final beat
	assign q_ready = load_en && ((state == SECOND) || !split);

	// ==============================
	// output register and state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			req_valid <= 1'b0;
			state <= ISSUE;
		end else if (load_en) begin
			req_valid <= q_valid;
			if (q_valid) begin
				if (state == SECOND)
					state <= ISSUE;
				else if (split)
					state <= SECOND;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_en && q_valid) begin
			req <= next_req;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the address path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
	--top-module tb_agen_top -Mdir obj_dir

out=$(./obj_dir/Vtb_agen_top)
echo "$out"

if echo "$out" | grep -q "^=== PASS ===$"; then
	exit 0
fi
exit 1

// File: test/agen_testdata.txt
// kind 1 op: test opcode size base index scale disp (opcode 0 nop 1 ld 2 st 3 amo)
// kind 2 expected request: test addr store size first last err, kind 0 ends the data
1 1 1 3 10000000 00000010 3 008
2 1 10000088 0 3 1 1 0
1 1 2 2 20000100 00000004 2 ff0
2 1 20000100 1 2 1 1 0
1 1 1 1 00003000 00000007 1 800
2 1 0000280e 0 1 1 1 0
1 1 2 0 00000040 00000000 0 fff
2 1 0000003f 1 0 1 1 0
1 2 3 2 40000000 00000020 3 7ff
2 2 40000020 1 2 1 1 0
1 2 3 3 00010000 fffffff8 2 100
2 2 0000fff8 1 3 1 1 0
1 3 1 3 00001000 0000003c 0 000
2 3 0000103c 0 3 1 0 0
2 3 00001040 0 3 0 1 0
1 3 2 3 ffffffc0 00000000 0 03c
2 3 fffffffc 1 3 1 0 0
2 3 00000000 1 3 0 1 0
1 4 3 3 00003000 0000003c 3 010
2 4 0000303c 1 3 1 1 1
1 4 0 0 12345678 00000001 1 004
1 4 1 0 00000100 00000001 0 000
2 4 00000101 0 0 1 1 0
1 5 1 2 00008000 00000001 2 000
2 5 00008004 0 2 1 1 0
1 5 1 3 00008000 00000007 3 004
2 5 0000803c 0 3 1 0 0
2 5 00008040 0 3 0 1 0
1 5 2 1 00009000 00000000 0 ffe
2 5 00008ffe 1 1 1 1 0
1 5 3 2 0000a000 00000010 0 000
2 5 0000a010 1 2 1 1 0
1 5 2 2 0000b000 0000000f 2 002
2 5 0000b03e 1 2 1 0 0
2 5 0000b040 1 2 0 1 0
0 0 0 0 00000000 00000000 0 000

// File: test/tb_agen_top.sv
// address path testbench
`timescale 1ns/1ps

module tb_agen_top;

	localparam int HALF = 4;
	// data file records of eight words each
	localparam int MAX_REC = 64;

	logic clk;
	logic rst;
	logic op_valid;
	agen_pkg::mem_op_t op;
	logic op_ready;
	logic req_valid;
	agen_pkg::line_req_t req;
	logic req_ready;

	logic [31:0] raw [0:MAX_REC*8-1];
	agen_pkg::mem_op_t ops [0:MAX_REC-1];
	agen_pkg::line_req_t exp_req [0:MAX_REC-1];
	int exp_test [0:MAX_REC-1];
	int n_ops;
	int n_exp;
	int op_idx;
	int exp_idx;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	logic [31:0] lcg_state;
	logic op_fire;
	logic req_fire;
	logic saw_stall;
	logic loaded;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	agen_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.op        (op),
		.op_ready  (op_ready),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready)
	);

	// ==============================
	// helpers
	// ==============================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, want);
			errors++;
			test_errors++;
		end
	endtask

	// kind 1 is an operation and kind 2 an expected request, anything else ends it
	task automatic load_data();
		$readmemh("test/agen_testdata.txt", raw);
		for (int i = 0; i < MAX_REC * 8; i += 8) begin
			if (raw[i] === 32'd1) begin
				ops[n_ops].opcode = agen_pkg::opcode_e'(raw[i+2][1:0]);
				ops[n_ops].size = agen_pkg::size_e'(raw[i+3][1:0]);
				ops[n_ops].base = raw[i+4];
				ops[n_ops].index = raw[i+5];
				ops[n_ops].scale = raw[i+6][1:0];
				ops[n_ops].disp = raw[i+7][11:0];
				n_ops++;
			end else if (raw[i] === 32'd2) begin
				exp_test[n_exp] = raw[i+1];
				exp_req[n_exp].addr = raw[i+2];
				exp_req[n_exp].store = raw[i+3][0];
				exp_req[n_exp].size = agen_pkg::size_e'(raw[i+4][1:0]);
				exp_req[n_exp].first = raw[i+5][0];
				exp_req[n_exp].last = raw[i+6][0];
				exp_req[n_exp].err = raw[i+7][0];
				n_exp++;
			end else begin
				break;
			end
		end
		if (n_exp == 0) begin
			$display("no expected requests found in the data file");
			errors++;
		end
	endtask

	task automatic finish_test(input int num);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d %s with %0d mismatches", num,
			(test_errors == 0) ? "passed" : "failed", test_errors);
		test_errors = 0;
	endtask

	// in order against the next expected entry
	task automatic check_request();
		if (exp_idx >= n_exp) begin
			$display("extra request at %0t ns for address %h after all expected ones",
				$time, req.addr);
			errors++;
		end else begin
			check_field("req.addr", req.addr, exp_req[exp_idx].addr);
			check_field("req.store", 32'(req.store), 32'(exp_req[exp_idx].store));
			check_field("req.size", 32'(req.size), 32'(exp_req[exp_idx].size));
			check_field("req.first", 32'(req.first), 32'(exp_req[exp_idx].first));
			check_field("req.last", 32'(req.last), 32'(exp_req[exp_idx].last));
			check_field("req.err", 32'(req.err), 32'(exp_req[exp_idx].err));
			// a test ends with its last expected request
			if (exp_idx == n_exp - 1 || exp_test[exp_idx + 1] != exp_test[exp_idx])
				finish_test(exp_test[exp_idx]);
			exp_idx++;
		end
	endtask

	// drive on the falling edge and sample just before the rising edge
	task automatic drive_cycle();
		@(negedge clk);
		if (op_fire)
			op_idx++;
		op_valid = (op_idx < n_ops);
		if (op_valid)
			op = ops[op_idx];
		lcg_state = lcg_next(lcg_state);
		// ready about three cycles in four
		req_ready = (lcg_state[17:16] != 2'b00);
		#(HALF - 1);
		op_fire = op_valid && op_ready;
		req_fire = req_valid && req_ready;
		// a full queue must push back on the operation input
		if (op_valid && !op_ready)
			saw_stall = 1'b1;
		if (req_fire)
			check_request();
	endtask

	// ==============================
	// checks outside the main flow
	// ==============================

	always @(negedge clk) begin
		if (rst && req_valid !== 1'b0) begin
			$display("request valid went high at %0t ns while reset was held", $time);
			errors++;
		end
	end

	// forty cycles per operation
	initial begin
		wait (loaded);
		#(n_ops * 40 * 2 * HALF);
		$display("run timed out with %0d expected requests still missing", n_exp - exp_idx);
		$display("=== FAIL ===");
		$finish;
	end

	// ==============================
	// main sequence
	// ==============================

	initial begin
		op_valid = 1'b0;
		op = '0;
		req_ready = 1'b0;
		lcg_state = 32'hcd3d;
		op_fire = 1'b0;
		req_fire = 1'b0;
		saw_stall = 1'b0;
		n_ops = 0;
		n_exp = 0;
		op_idx = 0;
		exp_idx = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		load_data();
		loaded = 1'b1;
		// an operation offered during reset must leave no trace
		@(negedge clk);
		op_valid = (n_ops > 0);
		op = ops[0];
		wait (!rst);
		op_valid = 1'b0;
		// ops go back to back so the queue fills under back-pressure
		while (op_idx < n_ops || exp_idx < n_exp)
			drive_cycle();
		// anything arriving now is a duplicate
		repeat (12) drive_cycle();
		if (!saw_stall) begin
			$display("back-pressure never reached the operation input");
			errors++;
		end
		$display("%0d tests, %0d failed, %0d of %0d requests seen, %0d errors",
			tests_run, tests_failed, exp_idx, n_exp, errors);
		if (errors == 0 && exp_idx == n_exp)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	// 8 ns period
	localparam int HALF = 4;

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	// held for five rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: vlog.f
logic/agen_pkg.sv
logic/agen_unit.sv
logic/agen_fifo.sv
logic/line_splitter.sv
logic/agen_top.sv
test/tb_clock.sv
test/tb_agen_top.sv
